/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := cpuTb
FILELIST := filelist.f
BUILDDIR := obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	@out="$$(./$(BUILDDIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qF "Simulation finished: PASS"

clean:
	rm -rf $(BUILDDIR)

/* filelist.f */
+incdir+include
src/cpuPkg.sv
src/instrDecode.sv
src/controlFsm.sv
src/regFile.sv
src/aluUnit.sv
src/datapath.sv
src/cpuTop.sv
tb/cpu_assertions.sv
tb/cpuTb.sv

/* include/cpu_defines.svh */
/*
 * cpu sizing constants
 * word width, register file shape, immediate width and reset vector
 */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data and address width
`define CPU_DATA_W 16

// r0..r7, r7 is the pc
`define CPU_REG_NUM 8
`define CPU_REG_IDX_W 3
`define CPU_PC_IDX 7

// DDDDDDDDD field of the instruction word
`define CPU_IMM_W 9

// first fetch address
`define CPU_RESET_PC 0

`endif

/* src/aluUnit.sv */
/*
 * alu with A and G registers and the c/n/z flag register
 * add, sub and and with A as the left operand and the bus as the right
 */
`default_nettype none

`include "cpu_defines.svh"

module aluUnit import cpuPkg::*; (
    input  logic  Clock,
    input  logic  rstN,
    input  wordT  bus,
    input  aluOpT aluOp,
    input  logic  aWr,
    input  logic  gWr,
    input  logic  flagWr,
    output wordT  g,
    output flagsT flags
);

    wordT a;
    wordT result;
    logic carry;

    always_ff @(posedge Clock) begin
        if (aWr) a <= bus;
        if (gWr) g <= result;
    end

    // carry out of the 17-bit sum
    always_comb begin
        case (aluOp)
            aluSub:  {carry, result} = {1'b0, a} + {1'b0, ~bus} + 1'b1;
            aluAnd: begin
                result = a & bus;
                carry  = 1'b0; // no carry for logic ops
            end
            default: {carry, result} = {1'b0, a} + {1'b0, bus};
        endcase
    end

    // flags come from the live result so cmp needs no G write
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
        end else if (flagWr) begin
            flags.c <= carry;
            flags.n <= result[`CPU_DATA_W-1];
            flags.z <= (result == '0);
        end
    end

endmodule

`default_nettype wire

/* src/controlFsm.sv */
/*
 * time-step control FSM
 * fetch, wait, load IR, then up to three execute steps per instruction
 */
`default_nettype none

module controlFsm import cpuPkg::*; (
    input  logic  Clock,
    input  logic  rstN,
    input  logic  run,
    input  instrT instr,
    input  flagsT flags,
    output ctrlT  ctrl,
    output logic  irWr,
    output logic  done
);

    tStepT  stepQ;
    tStepT  stepD;
    logic   condTrue;
    busSelT opndSel;
    aluOpT  aluSel;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            stepQ <= tFetch;
        end else begin
            stepQ <= stepD;
        end
    end

    // next step, short instructions return early on done
    always_comb begin
        case (stepQ)
            tFetch:   stepD = run ? tWaitMem : tFetch; // hold while stopped
            tWaitMem: stepD = tLoadIr;
            tLoadIr:  stepD = tExec1;
            tExec1:   stepD = done ? tFetch : tExec2;
            tExec2:   stepD = done ? tFetch : tExec3;
            tExec3:   stepD = tFetch;
            default:  stepD = tFetch;
        endcase
    end

    // branch condition against current flags
    always_comb begin
        case (condT'(instr.rX))
            condAl:  condTrue = 1'b1;
            condEq:  condTrue = flags.z;
            condNe:  condTrue = !flags.z;
            condCc:  condTrue = !flags.c;
            condCs:  condTrue = flags.c;
            condPl:  condTrue = !flags.n;
            condMi:  condTrue = flags.n;
            default: condTrue = 1'b0; // 111 never taken
        endcase
    end

    // second operand, register or immediate
    assign opndSel = instr.imm ? selImmSext : selRy;

    // alu function per opcode, cmp subtracts
    always_comb begin
        case (instr.opcode)
            opSub, opCmp: aluSel = aluSub;
            opAnd:        aluSel = aluAnd;
            default:      aluSel = aluAdd; // add and branch target
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.busSel = selPc;
        ctrl.aluOp  = aluSel;
        irWr        = 1'b0;
        done        = 1'b0;

        case (stepQ)
            tFetch: begin
                ctrl.busSel = selPc;
                ctrl.addrWr = 1'b1;
                ctrl.pcInc  = run; // pc moves only when running
            end
            tWaitMem: ; // synchronous memory latency
            tLoadIr: irWr = 1'b1;
            tExec1: begin
                case (instr.opcode)
                    opMv: begin
                        ctrl.busSel = opndSel;
                        ctrl.rxWr   = 1'b1;
                        done        = 1'b1;
                    end
                    opBr: begin
                        if (instr.imm) begin // mvt
                            ctrl.busSel = selImmHigh;
                            ctrl.rxWr   = 1'b1;
                            done        = 1'b1;
                        end else begin // branch, A <- pc
                            ctrl.busSel = selPc;
                            ctrl.aWr    = 1'b1;
                        end
                    end
                    opAdd, opSub, opAnd, opCmp: begin
                        ctrl.busSel = selRx;
                        ctrl.aWr    = 1'b1;
                    end
                    opLd, opSt: begin
                        ctrl.busSel = selRy; // address from rY
                        ctrl.addrWr = 1'b1;
                    end
                    default: ;
                endcase
            end
            tExec2: begin
                case (instr.opcode)
                    opAdd, opSub, opAnd: begin
                        ctrl.busSel = opndSel;
                        ctrl.gWr    = 1'b1;
                        ctrl.flagWr = 1'b1;
                    end
                    opCmp: begin
                        ctrl.busSel = opndSel;
                        ctrl.flagWr = 1'b1; // flags only, G untouched
                        done        = 1'b1;
                    end
                    opBr: begin
                        ctrl.busSel = selImmSext; // G <- pc + offset
                        ctrl.gWr    = 1'b1;
                    end
                    opSt: begin
                        ctrl.busSel = selRx;
                        ctrl.doutWr = 1'b1;
                        ctrl.wrNext = 1'b1;
                    end
                    default: ; // ld waits for memory
                endcase
            end
            tExec3: begin
                case (instr.opcode)
                    opAdd, opSub, opAnd: begin
                        ctrl.busSel = selG;
                        ctrl.rxWr   = 1'b1;
                    end
                    opLd: begin
                        ctrl.busSel = selDin;
                        ctrl.rxWr   = 1'b1;
                    end
                    opBr: begin
                        ctrl.busSel = selG;
                        ctrl.pcLoad = condTrue;
                    end
                    default: ; // st, w is high this step
                endcase
                done = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/cpuPkg.sv */
/*
 * cpu types
 * opcodes, branch conditions, time steps, bus sources and the control word
 */
`default_nettype none

`include "cpu_defines.svh"

package cpuPkg;

    typedef logic [`CPU_DATA_W-1:0] wordT;
    typedef logic [`CPU_REG_IDX_W-1:0] regIdxT;

    // III field, opBr is mvt when M=1
    typedef enum logic [2:0] {
        opMv  = 3'b000,
        opBr  = 3'b001,
        opAdd = 3'b010,
        opSub = 3'b011,
        opLd  = 3'b100,
        opSt  = 3'b101,
        opAnd = 3'b110,
        opCmp = 3'b111
    } opcodeT;

    // branch condition, carried in the rX field
    typedef enum logic [2:0] {
        condAl   = 3'b000,
        condEq   = 3'b001,
        condNe   = 3'b010,
        condCc   = 3'b011,
        condCs   = 3'b100,
        condPl   = 3'b101,
        condMi   = 3'b110,
        condLink = 3'b111 // never taken
    } condT;

    typedef enum logic [2:0] {
        tFetch, tWaitMem, tLoadIr, tExec1, tExec2, tExec3
    } tStepT;

    typedef enum logic [2:0] {
        selRx, selRy, selPc, selG, selImmSext, selImmHigh, selDin
    } busSelT;

    typedef enum logic [1:0] {
        aluAdd, aluSub, aluAnd
    } aluOpT;

    typedef struct packed {
        logic c; // carry out
        logic n; // sign of result
        logic z; // result zero
    } flagsT;

    typedef struct packed {
        opcodeT opcode;
        logic   imm;     // M bit, immediate operand
        regIdxT rX;      // also the branch condition
        regIdxT rY;
        wordT   immSext; // DDDDDDDDD sign extended
        wordT   immHigh; // low byte << 8 for mvt
    } instrT;

    typedef struct packed {
        busSelT busSel;
        aluOpT  aluOp;
        logic   rxWr;
        logic   aWr;
        logic   gWr;
        logic   flagWr;
        logic   addrWr;
        logic   doutWr;
        logic   wrNext;  // w goes high next cycle
        logic   pcInc;
        logic   pcLoad;
    } ctrlT;

endpackage

`default_nettype wire

/* src/cpuTop.sv */
/*
 * multicycle bus processor, top level
 * decoder, control FSM and datapath
 */
`default_nettype none

module cpuTop import cpuPkg::*; (
    input  logic Clock,
    input  logic rstN,
    input  logic run,
    input  wordT din,
    output wordT addr,
    output wordT dout,
    output logic w,
    output logic done
);

    instrT instr;
    ctrlT  ctrl;
    flagsT flags;
    logic  irWr;

    instrDecode instrDecode_i (
        .Clock (Clock),
        .rstN  (rstN),
        .irWr  (irWr),
        .din   (din),
        .instr (instr)
    );

    controlFsm controlFsm_i (
        .Clock (Clock),
        .rstN  (rstN),
        .run   (run),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl),
        .irWr  (irWr),
        .done  (done)
    );

    datapath datapath_i (
        .Clock (Clock),
        .rstN  (rstN),
        .ctrl  (ctrl),
        .instr (instr),
        .din   (din),
        .flags (flags),
        .addr  (addr),
        .dout  (dout),
        .w     (w)
    );

endmodule

`default_nettype wire

/* src/datapath.sv */
/*
 * datapath, internal bus mux and the memory-side registers
 * holds the register file and alu
 */
`default_nettype none

module datapath import cpuPkg::*; (
    input  logic  Clock,
    input  logic  rstN,
    input  ctrlT  ctrl,
    input  instrT instr,
    input  wordT  din,
    output flagsT flags,
    output wordT  addr,
    output wordT  dout,
    output logic  w
);

    wordT bus;
    wordT rxVal;
    wordT ryVal;
    wordT pc;
    wordT g;

    regFile regFile_i (
        .Clock  (Clock),
        .rstN   (rstN),
        .bus    (bus),
        .wrEn   (ctrl.rxWr),
        .wrIdx  (instr.rX),   // only rX is ever a destination
        .pcInc  (ctrl.pcInc),
        .pcLoad (ctrl.pcLoad),
        .rdX    (instr.rX),
        .rdY    (instr.rY),
        .rxVal  (rxVal),
        .ryVal  (ryVal),
        .pc     (pc)
    );

    aluUnit aluUnit_i (
        .Clock  (Clock),
        .rstN   (rstN),
        .bus    (bus),
        .aluOp  (ctrl.aluOp),
        .aWr    (ctrl.aWr),
        .gWr    (ctrl.gWr),
        .flagWr (ctrl.flagWr),
        .g      (g),
        .flags  (flags)
    );

    // one bus source per step
    always_comb begin
        case (ctrl.busSel)
            selRx:      bus = rxVal;
            selRy:      bus = ryVal;
            selPc:      bus = pc;
            selG:       bus = g;
            selImmSext: bus = instr.immSext;
            selImmHigh: bus = instr.immHigh;
            selDin:     bus = din;
            default:    bus = '0;
        endcase
    end

    // memory port, w trails wrNext by one cycle
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            addr <= '0;
            dout <= '0;
            w    <= 1'b0;
        end else begin
            if (ctrl.addrWr) addr <= bus;
            if (ctrl.doutWr) dout <= bus;
            w <= ctrl.wrNext;
        end
    end

endmodule

`default_nettype wire

/* src/instrDecode.sv */
/*
 * instruction register and field decode
 * splits IR into opcode, register fields and both immediate forms
 */
`default_nettype none

`include "cpu_defines.svh"

module instrDecode import cpuPkg::*; (
    input  logic  Clock,
    input  logic  rstN,
    input  logic  irWr,
    input  wordT  din,
    output instrT instr
);

    wordT irQ;

    // capture memory word in tLoadIr
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            irQ <= '0;
        end else if (irWr) begin
            irQ <= din;
        end
    end

    // format III M XXX DDDDDDDDD, rY in the low 3 bits
    always_comb begin
        instr.opcode = opcodeT'(irQ[15:13]);
        instr.imm    = irQ[12];
        instr.rX     = irQ[11:9];
        instr.rY     = irQ[2:0];
        instr.immSext = {{(`CPU_DATA_W - `CPU_IMM_W){irQ[`CPU_IMM_W-1]}},
                         irQ[`CPU_IMM_W-1:0]};
        instr.immHigh = {irQ[7:0], 8'h00}; // mvt operand
    end

endmodule

`default_nettype wire

/* src/regFile.sv */
/*
 * register file, r0..r6 plus the pc in r7
 * pc loads from the bus or increments
 */
`default_nettype none

`include "cpu_defines.svh"

module regFile import cpuPkg::*; (
    input  logic   Clock,
    input  logic   rstN,
    input  wordT   bus,
    input  logic   wrEn,
    input  regIdxT wrIdx,
    input  logic   pcInc,
    input  logic   pcLoad,
    input  regIdxT rdX,
    input  regIdxT rdY,
    output wordT   rxVal,
    output wordT   ryVal,
    output wordT   pc
);

    wordT regs [`CPU_REG_NUM-1];
    wordT view [`CPU_REG_NUM];   // r0..r7 as seen by the read ports
    logic pcWr;

    // general registers
    always_ff @(posedge Clock) begin
        for (int i = 0; i < `CPU_REG_NUM - 1; i++) begin
            if (wrEn && wrIdx == regIdxT'(i)) begin
                regs[i] <= bus;
            end
        end
    end

    // write to r7 or a taken branch
    assign pcWr = pcLoad || (wrEn && wrIdx == regIdxT'(`CPU_PC_IDX));

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            pc <= wordT'(`CPU_RESET_PC);
        end else if (pcWr) begin
            pc <= bus; // load wins over increment
        end else if (pcInc) begin
            pc <= pc + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < `CPU_REG_NUM - 1; i++) begin
            view[i] = regs[i];
        end
        view[`CPU_PC_IDX] = pc;
    end

    assign rxVal = view[rdX];
    assign ryVal = view[rdY];

endmodule

`default_nettype wire

/* tb/cpuTb.sv */
/*
 * testbench for the multicycle bus processor
 * runs directed programs against a synchronous memory model
 */
`default_nettype none

`include "cpu_defines.svh"

module cpuTb import cpuPkg::*; ();

    localparam int ClkPeriod = 40;
    localparam int NumInstr  = 700;              // bound on instructions over all tests
    localparam int MemWords  = 1 << `CPU_DATA_W;

    logic Clock;
    logic rstN;
    logic run;
    wordT din;
    wordT addr;
    wordT dout;
    logic w;
    logic done;

    wordT        mem [MemWords];
    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;
    int          progLen;     // next free program word
    int          wCycles;     // cycles with w high
    wordT        wrAddr [$];  // stores seen on the port
    wordT        wrData [$];
    wordT        expAddr [$]; // stores the program should make
    wordT        expData [$];

    cpuTop cpuTop_i (
        .Clock (Clock),
        .rstN  (rstN),
        .run   (run),
        .din   (din),
        .addr  (addr),
        .dout  (dout),
        .w     (w),
        .done  (done)
    );

    initial begin
        Clock = 1'b0;
        forever #(ClkPeriod / 2) Clock = ~Clock;
    end

    // synchronous memory, din follows addr by one edge
    always @(posedge Clock) begin
        din <= mem[addr];
        if (w) begin
            mem[addr] = dout; // old word already read above
        end
    end

    // log every store on the port
    always @(negedge Clock) begin
        if (w) begin
            wCycles++;
            wrAddr.push_back(addr);
            wrData.push_back(dout);
        end
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsrBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic wordT randBits(input int n);
        wordT v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsrBit()}; // one step per bit
        end
        return v;
    endfunction

    // instruction words, III M XXX DDDDDDDDD
    function automatic wordT encReg(input opcodeT op, input regIdxT rx, input regIdxT ry);
        return {op, 1'b0, rx, 6'b0, ry};
    endfunction

    function automatic wordT encImm(input opcodeT op, input regIdxT rx, input logic [8:0] imm);
        return {op, 1'b1, rx, imm};
    endfunction

    function automatic wordT encBranch(input condT cond, input logic [8:0] offset);
        return {opBr, 1'b0, cond, offset};
    endfunction

    function automatic wordT encMvt(input regIdxT rx, input logic [7:0] value);
        return {opBr, 1'b1, rx, 1'b0, value};
    endfunction

    // reference alu, carry in bit 16
    function automatic logic [16:0] aluRef(input opcodeT op, input wordT a, input wordT b);
        case (op)
            opSub, opCmp: return {1'b0, a} + {1'b0, ~b} + 17'd1;
            opAnd:        return {1'b0, a & b}; // no carry
            default:      return {1'b0, a} + {1'b0, b};
        endcase
    endfunction

    function automatic logic condHolds(input condT cond, input logic [16:0] r);
        case (cond)
            condAl:  return 1'b1;
            condEq:  return r[15:0] == '0;
            condNe:  return r[15:0] != '0;
            condCc:  return !r[16];
            condCs:  return r[16];
            condPl:  return !r[15];
            condMi:  return r[15];
            default: return 1'b0; // 111 never branches
        endcase
    endfunction

    task automatic checkWord(input string name, input wordT actual, input wordT expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at time %0t: %s is 0x%h, expected 0x%h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at time %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    task automatic emit(input wordT instrWord);
        mem[progLen] = instrWord;
        progLen++;
    endtask

    task automatic expectStore(input wordT a, input wordT d);
        expAddr.push_back(a);
        expData.push_back(d);
    endtask

    task automatic resetCpu();
        for (int i = 0; i < MemWords; i++) begin
            mem[i] = wordT'(i) ^ 16'h5aa5; // pattern covers all address bits
        end
        @(posedge Clock);
        rstN <= 1'b0;
        run  <= 1'b0;
        repeat (2) @(posedge Clock);
        rstN <= 1'b1;
        progLen = 0;
        wCycles = 0;
        wrAddr.delete();
        wrData.delete();
        expAddr.delete();
        expData.delete();
    endtask

    // run from address 0 until nInstr done pulses, then hold in fetch
    task automatic runProgram(input int nInstr);
        int seen;
        seen = 0;
        @(posedge Clock);
        run <= 1'b1;
        while (seen < nInstr) begin
            @(negedge Clock);
            if (done) begin
                seen++;
            end
        end
        @(posedge Clock);
        run <= 1'b0;        // fsm sees it in the next fetch
        @(negedge Clock);   // last store has landed
    endtask

    task automatic checkStores();
        checkWord("w cycles", wordT'(wCycles), wordT'(expAddr.size()));
        for (int i = 0; i < expAddr.size(); i++) begin
            if (i < wrAddr.size()) begin
                checkWord("addr", wrAddr[i], expAddr[i]);
                checkWord("dout", wrData[i], expData[i]);
            end
            checkWord("mem", mem[expAddr[i]], expData[i]);
        end
    endtask

    task automatic testResetFetch();
        resetCpu();
        @(negedge Clock);
        checkBit("w", w, 1'b0);
        checkBit("done", done, 1'b0);
        checkWord("addr", addr, 16'h0000);
        checkWord("dout", dout, 16'h0000);
        emit(encImm(opMv, 3'd1, 9'd3));
        emit(encImm(opMv, 3'd2, 9'd4)); // must never run
        // run high for one fetch only
        @(posedge Clock);
        run <= 1'b1;
        @(posedge Clock);
        run <= 1'b0;
        while (!done) begin
            @(negedge Clock);
        end
        checkWord("addr", addr, 16'h0000); // first fetch came from word 0
        repeat (8) begin
            @(negedge Clock);
            checkBit("done", done, 1'b0);
            checkBit("w", w, 1'b0);
        end
        checkWord("addr", addr, 16'h0001); // pc parked after one fetch
    endtask

    task automatic testMoves();
        resetCpu();
        emit(encImm(opMv, 3'd2, 9'h1fb)); // -5, sign extended
        emit(encMvt(3'd3, 8'ha7));
        emit(encReg(opMv, 3'd4, 3'd2));
        emit(encImm(opMv, 3'd6, 9'h080));
        emit(encReg(opSt, 3'd3, 3'd6));
        emit(encImm(opMv, 3'd6, 9'h081));
        emit(encReg(opSt, 3'd4, 3'd6));
        expectStore(16'h0080, 16'ha700);
        expectStore(16'h0081, 16'hfffb);
        runProgram(progLen);
        checkStores();
    endtask

    task automatic testAlu();
        wordT        a;
        wordT        b;
        wordT        imm;
        logic [16:0] r;
        opcodeT      ops [3];
        resetCpu();
        ops = '{opAdd, opSub, opAnd};
        a = randBits(16);
        b = randBits(16);
        mem[16'h0090] = a;
        mem[16'h0091] = b;
        emit(encImm(opMv, 3'd6, 9'h090));
        emit(encReg(opLd, 3'd0, 3'd6));
        emit(encImm(opAdd, 3'd6, 9'd1));
        emit(encReg(opLd, 3'd1, 3'd6));
        emit(encImm(opMv, 3'd5, 9'h0a0)); // result pointer
        for (int k = 0; k < 6; k++) begin
            emit(encReg(opMv, 3'd2, 3'd0));
            if (k < 3) begin
                emit(encReg(ops[k], 3'd2, 3'd1));
                r = aluRef(ops[k], a, b);
            end else begin
                imm = randBits(9);
                emit(encImm(ops[k - 3], 3'd2, imm[8:0]));
                r = aluRef(ops[k - 3], a, {{7{imm[8]}}, imm[8:0]});
            end
            emit(encReg(opSt, 3'd2, 3'd5));
            emit(encImm(opAdd, 3'd5, 9'd1));
            expectStore(wordT'(16'h00a0 + k), r[15:0]);
        end
        runProgram(progLen);
        checkStores();
    endtask

    task automatic testLoadStore();
        wordT value;
        resetCpu();
        value = randBits(16);
        mem[16'h00c0] = value;
        emit(encImm(opMv, 3'd5, 9'h0c0));
        emit(encReg(opLd, 3'd3, 3'd5));   // r5 is a plain pointer
        emit(encImm(opMv, 3'd6, 9'h0c8));
        emit(encReg(opSt, 3'd3, 3'd6));
        emit(encImm(opMv, 3'd5, 9'h0c9));
        emit(encReg(opSt, 3'd3, 3'd5));
        expectStore(16'h00c8, value);
        expectStore(16'h00c9, value);
        runProgram(progLen);
        checkStores();
    endtask

    // cmp then branch, the store address tells which path ran
    task automatic testBranch(input condT cond, input wordT a, input wordT b, input logic useImm);
        wordT        bEff;
        logic [16:0] r;
        logic        taken;
        int          branchAt;
        resetCpu();
        bEff = useImm ? {{7{b[8]}}, b[8:0]} : b;
        mem[16'h00f0] = a;
        mem[16'h00f1] = b;
        emit(encImm(opMv, 3'd4, 9'h0d0)); // not-taken slot
        emit(encImm(opMv, 3'd5, 9'h0d8)); // taken slot
        emit(encImm(opMv, 3'd6, 9'h0f0));
        emit(encReg(opLd, 3'd0, 3'd6));
        emit(encImm(opAdd, 3'd6, 9'd1));
        emit(encReg(opLd, 3'd1, 3'd6));
        emit(encImm(opMv, 3'd2, 9'h055)); // marker
        if (useImm) begin
            emit(encImm(opCmp, 3'd0, b[8:0]));
        end else begin
            emit(encReg(opCmp, 3'd0, 3'd1));
        end
        branchAt = progLen;
        emit(encBranch(cond, 9'd2));      // lands on branchAt + 3
        emit(encReg(opSt, 3'd2, 3'd4));
        emit(encBranch(condAl, 9'd1));    // hop over the taken store
        emit(encReg(opSt, 3'd2, 3'd5));
        emit(encBranch(condAl, 9'h1ff));  // halt, branch to itself
        r = aluRef(opCmp, a, bEff);
        taken = condHolds(cond, r);
        expectStore(taken ? 16'h00d8 : 16'h00d0, 16'h0055);
        runProgram(branchAt + (taken ? 2 : 3));
        checkStores();
    endtask

    task automatic testBranches();
        wordT pairA [5];
        wordT pairB [5];
        // equal, negative no carry, negative with carry, small positive, random
        pairA = '{16'h0005, 16'h0003, 16'h9000, 16'h0100, 16'h0000};
        pairB = '{16'h0005, 16'h0007, 16'h1000, 16'hfffe, 16'h0000};
        pairA[4] = randBits(16);
        pairB[4] = randBits(16);
        for (int p = 0; p < 5; p++) begin
            for (int c = 0; c < 8; c++) begin
                testBranch(condT'(c), pairA[p], pairB[p], p == 1 || p == 3);
            end
        end
    endtask

    initial begin
        rstN <= 1'b0;
        run  <= 1'b0;
        din  <= '0;
        lfsrState  = 32'ha347_a8bb;
        errorCount = 0;
        checkCount = 0;
        progLen    = 0;
        wCycles    = 0;
        testResetFetch();
        testMoves();
        repeat (4) testAlu();
        testLoadStore();
        testBranches();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // six cycles per instruction at most, four times over
    initial begin
        #(NumInstr * 6 * ClkPeriod * 4);
        $display("Error: watchdog expired, the DUT stopped completing instructions");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/cpu_assertions.sv */
/*
 * protocol assertions for the cpu top level
 * write strobe, done pulse and quiet outputs under reset
 */
`default_nettype none

module cpuAssertions (
    input logic Clock,
    input logic rstN,
    input logic w,
    input logic done
);

    // a store strobes w for a single cycle
    wSinglePulse: assert property (@(posedge Clock) disable iff (!rstN) w |=> !w)
        else $error("w stayed high for two cycles in a row");

    // one done per instruction, never stretched
    doneSinglePulse: assert property (@(posedge Clock) disable iff (!rstN) done |=> !done)
        else $error("done stayed high for two cycles in a row");

    quietInReset: assert property (@(posedge Clock) !rstN |-> !w && !done)
        else $error("w or done active while reset is asserted"); // memory side idle

endmodule

bind cpuTop cpuAssertions cpuAssertions_i (
    .Clock (Clock),
    .rstN  (rstN),
    .w     (w),
    .done  (done)
);

`default_nettype wire
